// ==== compile.f ====
+incdir+include
rtl/rf_pkg.sv
rtl/rf_ram.sv
rtl/rf_ram_if.sv
rtl/rf_top.sv
verif/tb_rf_top.sv

// ==== rtl/rf_pkg.sv ====
`default_nettype none

package rf_pkg;

   // Register width of the core
   // One serial transfer moves one register in XLEN cycles
   localparam int XLEN = 32;

   // General registers x0..x31
   localparam int NUM_GPR = 32; // CSR slots follow from this index

   // How much of the control logic gets a reset
   typedef enum logic {
      RST_MINI, // Only the flops the bridge needs to start cleanly
      RST_NONE  // Rely on power-up values
   } rst_strategy_e;

endpackage

`default_nettype wire

// ==== rtl/rf_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

// Simple dual-port SRAM model, one write port and one read port
module rf_ram #(
   parameter int WIDTH = 8,
   parameter int AW    = 8
) (
   input  wire              i_clk,
   input  wire  [AW-1:0]    i_waddr,
   input  wire  [WIDTH-1:0] i_wdata,
   input  wire              i_wen,
   input  wire  [AW-1:0]    i_raddr,
   input  wire              i_ren,
   output logic [WIDTH-1:0] o_rdata
);

   localparam int DEPTH = 2 ** AW;

   logic [WIDTH-1:0] mem [DEPTH];

   // Write port
   always_ff @(posedge i_clk) begin
      if (i_wen) begin
         mem[i_waddr] <= i_wdata;
      end
   end

   // Registered read, output holds between enables
   always_ff @(posedge i_clk) begin
      if (i_ren) begin
         o_rdata <= mem[i_raddr]; // Old data on a same-address write
      end
   end

endmodule

`default_nettype wire

// ==== rtl/rf_ram_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// Bridge between the two serial register ports of the core and a word-wide SRAM
module rf_ram_if #(
   parameter int                    WIDTH          = 8,
   parameter int                    CSR_REGS       = 4,
   parameter rf_pkg::rst_strategy_e RESET_STRATEGY = rf_pkg::RST_MINI,
   // Register number width, GPRs plus CSRs
   localparam int                   RAW            = $clog2(rf_pkg::NUM_GPR + CSR_REGS),
   localparam int                   L2W            = $clog2(WIDTH),
   localparam int                   AW             = $clog2(rf_pkg::XLEN) + RAW - L2W
) (
   input  wire              i_clk,
   input  wire              i_rst,
   // Core side
   input  wire              i_rreq,
   input  wire              i_wreq,
   output logic             o_ready,
   input  wire  [RAW-1:0]   i_wreg0,
   input  wire  [RAW-1:0]   i_wreg1,
   input  wire              i_wen0,
   input  wire              i_wen1,
   input  wire              i_wdata0,
   input  wire              i_wdata1,
   input  wire  [RAW-1:0]   i_rreg0,
   input  wire  [RAW-1:0]   i_rreg1,
   output logic             o_rdata0,
   output logic             o_rdata1,
   // SRAM side
   output logic [AW-1:0]    o_waddr,
   output logic [WIDTH-1:0] o_wdata,
   output logic             o_wen,
   output logic [AW-1:0]    o_raddr,
   output logic             o_ren,
   input  wire  [WIDTH-1:0] i_rdata
);

   import rf_pkg::*;

   localparam int CW = $clog2(XLEN); // Bit position counter width

   logic [CW-1:0]    rcnt;      // Bit position of the current transfer
   logic [CW-1:0]    wcnt;
   logic [2:0]       rreq_sr;   // Read request delay line towards o_ready
   logic             rgate;     // Read transfer in progress
   logic             wgate;     // Write words still to be stored
   logic             wwrap;     // rcnt has wrapped during the write
   logic             rtrig0;
   logic             rtrig1;
   logic             wtrig0;
   logic             wtrig1;

   logic [WIDTH-1:0] wdata0_r;
   logic [WIDTH:0]   wdata1_r;  // One extra bit, port 1 word goes out a cycle later
   logic             wen0_r;
   logic             wen1_r;
   logic [RAW-1:0]   wreg;

   logic [RAW-1:0]   rreg;
   logic [WIDTH-1:0] rdata0;
   logic [WIDTH-2:0] rdata1;

   // Writes are accepted at once, reads once bit 0 is on the outputs
   assign o_ready = rreq_sr[2] | i_wreq;

   // Write side runs four positions behind the counter
   assign wcnt = rcnt - CW'(4);

   always_ff @(posedge i_clk) begin
      if (i_rst && (RESET_STRATEGY != RST_NONE)) begin
         rcnt    <= '0;
         rreq_sr <= '0;
         rgate   <= 1'b0;
         wgate   <= 1'b0;
         wwrap   <= 1'b0;
      end else begin
         rcnt    <= rcnt + CW'(1);
         rreq_sr <= {rreq_sr[1:0], i_rreq};

         if (&rcnt | i_rreq | i_wreq) begin
            rgate <= i_rreq; // Reads stop after the last word
         end

         if (&rcnt) begin
            wwrap <= 1'b1;
         end
         if (wwrap && (&wcnt)) begin
            wgate <= 1'b0; // Last port 1 word stored this cycle
         end

         // A request restarts the position count
         if (i_rreq | i_wreq) begin
            rcnt  <= i_wreq ? CW'(2) : '0;
            wgate <= i_wreq;
            wwrap <= 1'b0;
         end
      end
   end

   // Word boundary strobes
   assign rtrig0 = (rcnt[L2W-1:0] == L2W'(1));
   assign wtrig0 = rtrig1;

   generate
      if (WIDTH == 2) begin : gen_wtrig_w2
         assign wtrig1 = wcnt[0];
      end else begin : gen_wtrig_wide
         logic wtrig0_r;

         always_ff @(posedge i_clk) begin
            wtrig0_r <= wtrig0;
         end

         assign wtrig1 = wtrig0_r;
      end
   endgenerate

   // Write path
   always_ff @(posedge i_clk) begin
      wdata0_r <= {i_wdata0, wdata0_r[WIDTH-1:1]}; // LSB first
      wdata1_r <= {i_wdata1, wdata1_r[WIDTH:1]};

      if (i_wreq) begin
         wen0_r <= 1'b0; // No stale enable at the start of a write
         wen1_r <= 1'b0;
      end else if (wcnt[0]) begin
         wen0_r <= i_wen0;
         wen1_r <= i_wen1;
      end
   end

   assign o_wdata = wtrig1 ? wdata1_r[WIDTH-1:0] : wdata0_r;
   assign wreg    = wtrig1 ? i_wreg1 : i_wreg0;
   assign o_wen   = wgate & ((wtrig0 & wen0_r) | (wtrig1 & wen1_r));

   generate
      if (WIDTH == 32) begin : gen_waddr_w32
         assign o_waddr = wreg; // One word per register
      end else begin : gen_waddr_narrow
         assign o_waddr = {wreg, wcnt[CW-1:L2W]};
      end
   endgenerate

   // Read path
   // Port 0 is fetched first, port 1 on the following cycle
   assign rreg = rtrig0 ? i_rreg1 : i_rreg0;

   generate
      if (WIDTH == 32) begin : gen_raddr_w32
         assign o_raddr = rreg;
      end else begin : gen_raddr_narrow
         assign o_raddr = {rreg, rcnt[CW-1:L2W]};
      end
   endgenerate

   generate
      if (WIDTH == 2) begin : gen_ren_w2
         assign o_ren = rgate; // A new pair of reads every two cycles
      end else begin : gen_ren_wide
         assign o_ren = rgate & (rcnt[L2W-1:1] == '0);
      end
   endgenerate

   always_ff @(posedge i_clk) begin
      rtrig1 <= rtrig0;

      rdata0 <= {1'b0, rdata0[WIDTH-1:1]};
      if (rtrig0) begin
         rdata0 <= i_rdata;
      end
   end

   generate
      if (WIDTH == 2) begin : gen_rdata1_w2
         always_ff @(posedge i_clk) begin
            if (rtrig1) begin
               rdata1 <= i_rdata[1];
            end
         end
      end else begin : gen_rdata1_wide
         always_ff @(posedge i_clk) begin
            rdata1 <= {1'b0, rdata1[WIDTH-2:1]};
            if (rtrig1) begin
               rdata1 <= i_rdata[WIDTH-1:1]; // Bit 0 goes straight out
            end
         end
      end
   endgenerate

   assign o_rdata0 = rdata0[0];
   assign o_rdata1 = rtrig1 ? i_rdata[0] : rdata1[0];

endmodule

`default_nettype wire

// ==== rtl/rf_top.sv ====
`timescale 1ns/10ps
`default_nettype none

// Register file storage, serial bridge plus SRAM
module rf_top #(
   parameter int                    WIDTH          = 8, // 2, 4, 8, 16 or 32
   parameter int                    CSR_REGS       = 4,
   parameter rf_pkg::rst_strategy_e RESET_STRATEGY = rf_pkg::RST_MINI,
   localparam int                   RAW            = $clog2(rf_pkg::NUM_GPR + CSR_REGS),
   localparam int                   L2W            = $clog2(WIDTH),
   // SRAM word address width
   localparam int                   AW             = $clog2(rf_pkg::XLEN) + RAW - L2W
) (
   input  wire            i_clk,
   input  wire            i_rst,
   input  wire            i_rreq,
   input  wire            i_wreq,
   input  wire  [RAW-1:0] i_wreg0,
   input  wire  [RAW-1:0] i_wreg1,
   input  wire            i_wen0,
   input  wire            i_wen1,
   input  wire            i_wdata0,
   input  wire            i_wdata1,
   input  wire  [RAW-1:0] i_rreg0,
   input  wire  [RAW-1:0] i_rreg1,
   output logic           o_ready,
   output logic           o_rdata0,
   output logic           o_rdata1
);

   // Bridge to SRAM
   logic [AW-1:0]    ram_waddr;
   logic [WIDTH-1:0] ram_wdata;
   logic             ram_wen;
   logic [AW-1:0]    ram_raddr;
   logic             ram_ren;
   logic [WIDTH-1:0] ram_rdata;

   rf_ram_if #(
      .WIDTH          (WIDTH),
      .CSR_REGS       (CSR_REGS),
      .RESET_STRATEGY (RESET_STRATEGY)
   ) u_ram_if (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_rreq   (i_rreq),
      .i_wreq   (i_wreq),
      .o_ready  (o_ready),
      .i_wreg0  (i_wreg0),
      .i_wreg1  (i_wreg1),
      .i_wen0   (i_wen0),
      .i_wen1   (i_wen1),
      .i_wdata0 (i_wdata0),
      .i_wdata1 (i_wdata1),
      .i_rreg0  (i_rreg0),
      .i_rreg1  (i_rreg1),
      .o_rdata0 (o_rdata0),
      .o_rdata1 (o_rdata1),
      .o_waddr  (ram_waddr),
      .o_wdata  (ram_wdata),
      .o_wen    (ram_wen),
      .o_raddr  (ram_raddr),
      .o_ren    (ram_ren),
      .i_rdata  (ram_rdata)
   );

   // 2**AW words, GPRs first then CSRs
   rf_ram #(
      .WIDTH (WIDTH),
      .AW    (AW)
   ) u_ram (
      .i_clk   (i_clk),
      .i_waddr (ram_waddr),
      .i_wdata (ram_wdata),
      .i_wen   (ram_wen),
      .i_raddr (ram_raddr),
      .i_ren   (ram_ren),
      .o_rdata (ram_rdata)
   );

endmodule

`default_nettype wire

// ==== include/tb_rf_ref.svh ====
`ifndef TB_RF_REF_SVH
`define TB_RF_REF_SVH

// Expected register contents, GPRs then CSRs
logic [XLEN-1:0] model [NREGS];

// Expected value of one register
function automatic logic [XLEN-1:0] ref_read(input logic [RAW-1:0] idx);
   return model[idx];
endfunction

// Write transfer, bit 0 in the cycle after the request
task automatic do_write(
   input logic [RAW-1:0]  reg0,
   input logic [RAW-1:0]  reg1,
   input logic [XLEN-1:0] val0,
   input logic [XLEN-1:0] val1,
   input logic            en0,
   input logic            en1
);
   @(posedge i_clk);
   i_wreq  <= 1'b1;
   i_wreg0 <= reg0; // Held until the next request
   i_wreg1 <= reg1;
   i_wen0  <= en0;
   i_wen1  <= en1;
   @(negedge i_clk);
   if (o_ready !== 1'b1) begin
      $display("ERR %0t: o_ready low in the write request cycle", $time);
      errors++;
   end
   for (int k = 0; k < XLEN; k++) begin
      @(posedge i_clk);
      i_wreq   <= 1'b0;
      i_wdata0 <= val0[k]; // LSB first
      i_wdata1 <= val1[k];
   end
   // Port 1 word is stored after port 0, so it wins on a shared register
   if (en0) begin
      model[reg0] = val0;
   end
   if (en1) begin
      model[reg1] = val1;
   end
   repeat (8) @(posedge i_clk); // Last words reach the RAM in here
endtask

// Read transfer, the compare process checks the serial bits
task automatic do_read(
   input logic [RAW-1:0] reg0,
   input logic [RAW-1:0] reg1
);
   @(posedge i_clk);
   i_rreq  <= 1'b1;
   i_rreg0 <= reg0;
   i_rreg1 <= reg1;
   rd_q0.push_back(reg0);
   rd_q1.push_back(reg1);
   @(posedge i_clk);
   i_rreq <= 1'b0;
   while (rd_q0.size() != 0) begin
      @(posedge i_clk); // Entry is popped after all 32 bits
   end
   repeat (8) @(posedge i_clk);
endtask

`endif

// ==== verif/tb_rf_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_rf_top;

   import rf_pkg::*;

   localparam int WIDTH       = 8;
   localparam int CSR_REGS    = 4;
   localparam int NREGS       = NUM_GPR + CSR_REGS;
   localparam int RAW         = $clog2(NREGS);
   localparam int CLK_PERIOD  = 10;
   localparam int NUM_XFERS   = 250; // Upper bound on transfers in the run
   localparam int XFER_CYCLES = 50;
   localparam int NUM_RANDOM  = 200;

   logic           i_clk = 1'b0;
   logic           i_rst;
   logic           i_rreq;
   logic           i_wreq;
   logic [RAW-1:0] i_wreg0;
   logic [RAW-1:0] i_wreg1;
   logic           i_wen0;
   logic           i_wen1;
   logic           i_wdata0;
   logic           i_wdata1;
   logic [RAW-1:0] i_rreg0;
   logic [RAW-1:0] i_rreg1;
   logic           o_ready;
   logic           o_rdata0;
   logic           o_rdata1;

   int             errors = 0;
   integer         seed   = 32'hd1f7;
   logic [RAW-1:0] rd_q0 [$]; // Pending read register pairs
   logic [RAW-1:0] rd_q1 [$];

   rf_top #(
      .WIDTH          (WIDTH),
      .CSR_REGS       (CSR_REGS),
      .RESET_STRATEGY (RST_MINI)
   ) u_dut (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_rreq   (i_rreq),
      .i_wreq   (i_wreq),
      .i_wreg0  (i_wreg0),
      .i_wreg1  (i_wreg1),
      .i_wen0   (i_wen0),
      .i_wen1   (i_wen1),
      .i_wdata0 (i_wdata0),
      .i_wdata1 (i_wdata1),
      .i_rreg0  (i_rreg0),
      .i_rreg1  (i_rreg1),
      .o_ready  (o_ready),
      .o_rdata0 (o_rdata0),
      .o_rdata1 (o_rdata1)
   );

`include "tb_rf_ref.svh"

   // Initial fill, different for every register
   function automatic logic [XLEN-1:0] fill_value(input int idx);
      return 32'h9e37_79b9 * XLEN'(idx + 1);
   endfunction

   initial begin
      forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
   end

   // Collects both serial ports from the o_ready cycle on
   initial begin : compare_reads
      logic [RAW-1:0]  r0;
      logic [RAW-1:0]  r1;
      logic [XLEN-1:0] got0;
      logic [XLEN-1:0] got1;
      int              wait_cnt;
      forever begin
         @(negedge i_clk);
         if (rd_q0.size() != 0) begin
            r0       = rd_q0[0];
            r1       = rd_q1[0];
            wait_cnt = 0;
            while (o_ready !== 1'b1 && wait_cnt < 8) begin
               @(negedge i_clk);
               wait_cnt++;
            end
            if (o_ready !== 1'b1) begin
               $display("Read of registers %0d and %0d never raised o_ready", r0, r1);
               errors++;
            end else begin
               for (int k = 0; k < XLEN; k++) begin
                  got0[k] = o_rdata0;
                  got1[k] = o_rdata1;
                  if (k == 1 && o_ready !== 1'b0) begin
                     $display("ERR %0t: o_ready high for more than one read cycle", $time);
                     errors++;
                  end
                  if (k < XLEN - 1) begin
                     @(negedge i_clk);
                  end
               end
               if (got0 !== ref_read(r0)) begin
                  $display("ERR %0t: port 0 reg %0d expected %h got %h",
                           $time, r0, ref_read(r0), got0);
                  errors++;
               end
               if (got1 !== ref_read(r1)) begin
                  $display("ERR %0t: port 1 reg %0d expected %h got %h",
                           $time, r1, ref_read(r1), got1);
                  errors++;
               end
            end
            void'(rd_q0.pop_front());
            void'(rd_q1.pop_front());
         end
      end
   end

   initial begin : stimulus
      logic [31:0]     r;
      logic [RAW-1:0]  a0;
      logic [RAW-1:0]  a1;
      logic [XLEN-1:0] v0;
      logic [XLEN-1:0] v1;
      i_rst    = 1'b1;
      i_rreq   = 1'b0;
      i_wreq   = 1'b0;
      i_wreg0  = '0;
      i_wreg1  = '0;
      i_wen0   = 1'b0;
      i_wen1   = 1'b0;
      i_wdata0 = 1'b0;
      i_wdata1 = 1'b0;
      i_rreg0  = '0;
      i_rreg1  = '0;
      repeat (3) @(posedge i_clk);
      i_rst <= 1'b0;

      // Idle after reset
      repeat (10) begin
         @(negedge i_clk);
         if (o_ready !== 1'b0) begin
            $display("ERR %0t: o_ready high with no request", $time);
            errors++;
         end
         if (u_dut.ram_ren !== 1'b0) begin
            $display("ERR %0t: RAM read enable high with no request", $time);
            errors++;
         end
      end

      // Every register gets a known value first
      for (int i = 0; i < NREGS / 2; i++) begin
         do_write(RAW'(i), RAW'(i + NREGS / 2), fill_value(i), fill_value(i + NREGS / 2),
                  1'b1, 1'b1);
      end

      do_write(6'd5, 6'd9, 32'hcafe_0123, 32'h1234_5678, 1'b1, 1'b0);
      do_read(6'd5, 6'd5);

      do_write(6'd12, 6'd20, 32'ha5a5_0f0f, 32'h5a5a_f0f0, 1'b1, 1'b1);
      do_read(6'd20, 6'd12); // Ports swapped

      do_write(6'd7, 6'd30, 32'h0bad_f00d, 32'hdead_beef, 1'b1, 1'b0);
      do_read(6'd30, 6'd7); // Reg 30 keeps its fill value

      // CSRs against the GPRs
      do_write(6'd32, 6'd33, 32'h0c5e_0020, 32'h0c5e_0021, 1'b1, 1'b1);
      do_write(6'd34, 6'd35, 32'h0c5e_0022, 32'h0c5e_0023, 1'b1, 1'b1);
      for (int i = 0; i < NREGS / 2; i++) begin
         do_read(RAW'(i), RAW'(i + NREGS / 2));
      end

      for (int n = 0; n < NUM_RANDOM; n++) begin
         r  = $random(seed);
         a0 = RAW'(r[15:8] % NREGS);
         a1 = RAW'(r[23:16] % NREGS);
         if (r[0]) begin
            v0 = $random(seed);
            v1 = $random(seed);
            do_write(a0, a1, v0, v1, r[1], r[2]);
         end else begin
            do_read(a0, a1);
         end
      end

      repeat (4) @(posedge i_clk);
      $display("Finished with %0d errors", errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   initial begin : watchdog
      #(NUM_XFERS * XFER_CYCLES * CLK_PERIOD);
      $display("Timeout, the transfers did not finish in the expected time");
      $display("Finished with %0d errors", errors);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire
